/* verilog/autotest_pkg.sv */
// Shared constants and types for the SD self-test sequencer.
// Block layout assumes 512-byte SD blocks with a 13-byte header.
// Records are 24 bytes, so at most MAX_ITER of them fit after the header.
package autotest_pkg;

    localparam int          BLOCK_BYTES = 512;
    localparam logic [31:0] SIGNATURE   = 32'hAABBCCDD;
    localparam logic [31:0] FIRST_BLOCK = 32'h100;
    localparam int          HDR_BYTES   = 13;
    localparam int          REC_BYTES   = 24;
    localparam int          MAX_ITER    = 20;

    // hash core round count and key base
    localparam int          HASH_ROUNDS = 8;
    localparam logic [15:0] ROUND_KEY   = 16'h9E37;

    typedef logic [63:0]  plaintext_t;
    typedef logic [127:0] hash_t;
    typedef logic [63:0]  cycles_t;

    typedef enum logic [4:0] {
        ST_IDLE,
        ST_HOST_RST,
        ST_HOST_RST_WAIT,
        ST_RD_BLOCK,
        ST_RD_BLOCK_WAIT,
        ST_RD_BYTE,
        ST_RD_WAIT,
        ST_CHECK,
        ST_RUN_START,
        ST_RUN_WAIT,
        ST_WR_BLOCK,
        ST_WR_BLOCK_WAIT,
        ST_WR_FETCH,
        ST_WR_LOAD,
        ST_WR_BYTE,
        ST_WR_WAIT,
        ST_NEXT,
        ST_HALT
    } ctrl_state_t;

endpackage

/* verilog/autotest_ifs.sv */
// Internal links between the sequencer, the hash core and the block buffer.
// hash_if start is a single-cycle pulse; buf_if reads have one cycle of latency.
interface hash_if;
    import autotest_pkg::*;

    logic       start;
    plaintext_t plaintext;
    hash_t      hash;
    logic       done;

    modport ctrl (output start, output plaintext, input hash, input done);
    modport core (input start, input plaintext, output hash, output done);

endinterface

interface buf_if;

    logic [8:0] addr;
    logic       we;
    logic [7:0] wdata;
    logic [7:0] rdata;

    modport ctrl (output addr, output we, output wdata, input rdata);
    modport mem (input addr, input we, input wdata, output rdata);

endinterface

/* verilog/block_buffer.sv */
// Single-port 512x8 RAM holding the block body during a test run.
// Read data appears one cycle after the address; contents are not reset.
module block_buffer (
    input logic clk,
    buf_if.mem  bif
);
    import autotest_pkg::*;

    logic [7:0] mem [BLOCK_BYTES];
    logic [7:0] rdata_q;

    always_ff @(posedge clk)
    begin
        if (bif.we)
        begin
            mem[bif.addr] <= bif.wdata;
        end
        rdata_q <= mem[bif.addr];
    end

    // read-before-write on a shared address
    assign bif.rdata = rdata_q;

endmodule

/* verilog/hash_core.sv */
// Stand-in unit under test: 8-round rotate/xor hash over a 64-bit input.
// Fixed latency, done pulses HASH_ROUNDS cycles after start.
// A start while busy restarts the computation.
module hash_core (
    input logic  clk,
    input logic  rst,
    hash_if.core hif
);
    import autotest_pkg::*;

    typedef logic [$clog2(HASH_ROUNDS)-1:0] round_t;

    round_t round;
    logic   busy;
    logic   done_q;
    hash_t  state_q;

    // rotate left by 29, then xor in the replicated round key
    function automatic hash_t apply_round(input hash_t s, input logic [15:0] r);
        hash_t rot;
        rot = {s[98:0], s[127:99]};
        return rot ^ {8{ROUND_KEY + r}};
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            round  <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (hif.start)
            begin
                busy  <= 1'b1;
                round <= round_t'(1);
            end
            else if (busy)
            begin
                round <= round + round_t'(1);
                if (round == round_t'(HASH_ROUNDS - 1))
                begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // round 0 is applied as the plaintext is taken
    always_ff @(posedge clk)
    begin
        if (hif.start)
            state_q <= apply_round({hif.plaintext, ~hif.plaintext}, 16'd0);
        else if (busy)
            state_q <= apply_round(state_q, 16'(round));
    end

    assign hif.hash = state_q;
    assign hif.done = done_q;

endmodule

/* verilog/autotest_ctrl.sv */
// Self-test sequencer: reads a block, runs the hash core, writes the block back.
// Block commands wait for busy to rise and fall before the byte transfers.
// An error seen while busy is high halts with fault set; halt is terminal.
// Iteration counts above MAX_ITER are clamped, a count of 0 skips the block.
module autotest_ctrl (
    input  logic        clk,
    input  logic        rst,
    output logic        cmd_rst_o,
    output logic        cmd_rd_block_o,
    output logic        cmd_rd_byte_o,
    output logic        cmd_wr_block_o,
    output logic        cmd_wr_byte_o,
    output logic [31:0] block_addr_o,
    output logic [7:0]  wr_data_o,
    input  logic        busy_i,
    input  logic [7:0]  rd_data_i,
    input  logic        err_i,
    output logic        halt_o,
    output logic        fault_o,
    hash_if.ctrl        hif,
    buf_if.ctrl         bif
);
    import autotest_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        err_hit;

    logic [31:0] blk_q;
    logic [7:0]  iter_q;
    logic [9:0]  byte_cnt;
    logic        fault_q;

    logic [31:0] sig_q;
    logic [7:0]  count_q;
    plaintext_t  pt_q;
    hash_t       hash_q;
    cycles_t     timer_q;
    logic [7:0]  wr_data_q;

    logic [7:0]  iter_lim;
    logic [9:0]  rec_base;
    logic [9:0]  rec_off;
    logic [1:0]  sig_idx;
    logic [2:0]  pt_idx;
    logic [7:0]  out_byte;
    logic        rd_take;
    logic        last_byte;

    assign iter_lim  = (count_q > 8'(MAX_ITER)) ? 8'(MAX_ITER) : count_q;
    assign last_byte = (byte_cnt == 10'(BLOCK_BYTES - 1));
    assign rd_take   = (state == ST_RD_WAIT) && !busy_i;

    always_comb
    begin
        state_next     = state;
        cmd_rst_o      = 1'b0;
        cmd_rd_block_o = 1'b0;
        cmd_rd_byte_o  = 1'b0;
        cmd_wr_block_o = 1'b0;
        cmd_wr_byte_o  = 1'b0;
        err_hit        = 1'b0;
        case (state)
            ST_IDLE:
                state_next = ST_HOST_RST;
            ST_HOST_RST:
            begin
                cmd_rst_o = 1'b1;
                if (busy_i)
                    state_next = ST_HOST_RST_WAIT;
            end
            ST_HOST_RST_WAIT:
                if (!busy_i)
                    state_next = ST_RD_BLOCK;
            ST_RD_BLOCK:
            begin
                cmd_rd_block_o = 1'b1;
                if (busy_i)
                    state_next = ST_RD_BLOCK_WAIT;
            end
            ST_RD_BLOCK_WAIT:
            begin
                cmd_rd_block_o = 1'b1;
                if (!busy_i)
                    state_next = ST_RD_BYTE;
            end
            ST_RD_BYTE:
            begin
                cmd_rd_block_o = 1'b1;
                cmd_rd_byte_o  = 1'b1;
                if (busy_i)
                    state_next = ST_RD_WAIT;
            end
            ST_RD_WAIT:
            begin
                cmd_rd_block_o = 1'b1;
                if (!busy_i)
                    state_next = last_byte ? ST_CHECK : ST_RD_BYTE;
            end
            ST_CHECK:
            begin
                if (sig_q != SIGNATURE)
                    state_next = ST_HALT;
                else if (iter_lim == 8'd0)
                    state_next = ST_NEXT;
                else
                    state_next = ST_RUN_START;
            end
            ST_RUN_START:
                state_next = ST_RUN_WAIT;
            ST_RUN_WAIT:
                if (hif.done)
                    state_next = ST_WR_BLOCK;
            ST_WR_BLOCK:
            begin
                cmd_wr_block_o = 1'b1;
                if (busy_i)
                    state_next = ST_WR_BLOCK_WAIT;
            end
            ST_WR_BLOCK_WAIT:
            begin
                cmd_wr_block_o = 1'b1;
                if (!busy_i)
                    state_next = ST_WR_FETCH;
            end
            ST_WR_FETCH:
            begin
                cmd_wr_block_o = 1'b1;
                state_next     = ST_WR_LOAD;
            end
            ST_WR_LOAD:
            begin
                cmd_wr_block_o = 1'b1;
                state_next     = ST_WR_BYTE;
            end
            ST_WR_BYTE:
            begin
                cmd_wr_block_o = 1'b1;
                cmd_wr_byte_o  = 1'b1;
                if (busy_i)
                    state_next = ST_WR_WAIT;
            end
            ST_WR_WAIT:
            begin
                cmd_wr_block_o = 1'b1;
                if (!busy_i)
                    state_next = last_byte ? ST_NEXT : ST_WR_FETCH;
            end
            ST_NEXT:
                if (!busy_i)
                    state_next = ST_HOST_RST;
            ST_HALT:
                state_next = ST_HALT;
            default:
                state_next = ST_IDLE;
        endcase
        // host errors override whatever step is in progress
        if (err_i && busy_i && state != ST_IDLE && state != ST_HALT)
        begin
            state_next = ST_HALT;
            err_hit    = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            blk_q    <= FIRST_BLOCK;
            iter_q   <= '0;
            byte_cnt <= '0;
            fault_q  <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (err_hit)
                fault_q <= 1'b1;
            case (state)
                ST_RD_BLOCK, ST_WR_BLOCK:
                    byte_cnt <= '0;
                ST_RD_WAIT, ST_WR_WAIT:
                    if (!busy_i)
                        byte_cnt <= byte_cnt + 10'd1;
                ST_NEXT:
                    if (!busy_i)
                    begin
                        if (iter_q + 8'd1 < iter_lim)
                            iter_q <= iter_q + 8'd1;
                        else
                        begin
                            iter_q <= '0;
                            blk_q  <= blk_q + 32'd1;
                        end
                    end
                default:
                    ;
            endcase
        end
    end

    // header capture, run timing and outgoing byte
    always_ff @(posedge clk)
    begin
        if (rd_take)
        begin
            if (byte_cnt < 10'd4)
                sig_q <= {sig_q[23:0], rd_data_i};
            else if (byte_cnt == 10'd4)
                count_q <= rd_data_i;
            else if (byte_cnt < 10'(HDR_BYTES))
                pt_q <= {rd_data_i, pt_q[63:8]};
        end
        if (state == ST_RUN_START)
            timer_q <= '0;
        else if (state == ST_RUN_WAIT)
            timer_q <= timer_q + cycles_t'(1);
        if (state == ST_RUN_WAIT && hif.done)
            hash_q <= hif.hash;
        if (state == ST_WR_LOAD)
            wr_data_q <= out_byte;
    end

    assign rec_base = 10'(HDR_BYTES) + 10'(REC_BYTES) * {2'b00, iter_q};
    assign rec_off  = byte_cnt - rec_base;
    assign sig_idx  = 2'd3 - byte_cnt[1:0];
    assign pt_idx   = byte_cnt[2:0] - 3'd5;

    // header from registers, current record from the run, rest from the buffer
    always_comb
    begin
        out_byte = bif.rdata;
        if (byte_cnt < 10'd4)
            out_byte = sig_q[{sig_idx, 3'b000} +: 8];
        else if (byte_cnt == 10'd4)
            out_byte = count_q;
        else if (byte_cnt < 10'(HDR_BYTES))
            out_byte = pt_q[{pt_idx, 3'b000} +: 8];
        else if (byte_cnt >= rec_base && rec_off < 10'(REC_BYTES))
        begin
            if (rec_off < 10'($bits(hash_t) / 8))
                out_byte = hash_q[{rec_off[3:0], 3'b000} +: 8];
            else
                out_byte = timer_q[{rec_off[2:0], 3'b000} +: 8];
        end
    end

    // only the body goes to the buffer
    assign bif.addr  = byte_cnt[8:0];
    assign bif.we    = rd_take && (byte_cnt >= 10'(HDR_BYTES));
    assign bif.wdata = rd_data_i;

    assign hif.start     = (state == ST_RUN_START);
    assign hif.plaintext = pt_q;

    assign block_addr_o = blk_q;
    assign wr_data_o    = wr_data_q;
    assign halt_o       = (state == ST_HALT);
    assign fault_o      = fault_q;

endmodule

/* verilog/autotest_top.sv */
// Top level of the self-test sequencer with the byte-level SD host port.
// The SD host itself (SPI, card init, CRC) sits outside this design.
module autotest_top (
    input  logic        clk,
    input  logic        rst,
    output logic        cmd_rst_o,
    output logic        cmd_rd_block_o,
    output logic        cmd_rd_byte_o,
    output logic        cmd_wr_block_o,
    output logic        cmd_wr_byte_o,
    output logic [31:0] block_addr_o,
    output logic [7:0]  wr_data_o,
    input  logic        busy_i,
    input  logic [7:0]  rd_data_i,
    input  logic        err_i,
    output logic        halt_o,
    output logic        fault_o
);

    hash_if hif ();
    buf_if  bif ();

    autotest_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cmd_rst_o      (cmd_rst_o),
        .cmd_rd_block_o (cmd_rd_block_o),
        .cmd_rd_byte_o  (cmd_rd_byte_o),
        .cmd_wr_block_o (cmd_wr_block_o),
        .cmd_wr_byte_o  (cmd_wr_byte_o),
        .block_addr_o   (block_addr_o),
        .wr_data_o      (wr_data_o),
        .busy_i         (busy_i),
        .rd_data_i      (rd_data_i),
        .err_i          (err_i),
        .halt_o         (halt_o),
        .fault_o        (fault_o),
        .hif            (hif.ctrl),
        .bif            (bif.ctrl)
    );

    block_buffer u_buffer (
        .clk (clk),
        .bif (bif.mem)
    );

    hash_core u_core (
        .clk (clk),
        .rst (rst),
        .hif (hif.core)
    );

endmodule

/* dv/autotest_checker.sv */
// Handshake assertions for the SD host port, bound into the sequencer.
// fail_count is read by the testbench at the end of the run.
module autotest_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      cmd_rst_o,
    input logic                      cmd_rd_block_o,
    input logic                      cmd_rd_byte_o,
    input logic                      cmd_wr_block_o,
    input logic                      cmd_wr_byte_o,
    input logic                      busy_i,
    input logic [7:0]                wr_data_o,
    input autotest_pkg::ctrl_state_t state
);
    timeunit 1ns;
    timeprecision 1ps;
    import autotest_pkg::*;

    int fail_count = 0;

    cmd_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cmd_rst_o, cmd_rd_block_o, cmd_wr_block_o})
        && !(cmd_rd_byte_o && cmd_wr_byte_o))
    else
    begin
        fail_count++;
        $error("SD commands active at the same time");
    end

    // byte and reset commands are single requests
    cmd_drop: assert property (@(posedge clk) disable iff (rst)
        (cmd_rst_o || cmd_rd_byte_o || cmd_wr_byte_o) && busy_i
        |=> !(cmd_rst_o || cmd_rd_byte_o || cmd_wr_byte_o))
    else
    begin
        fail_count++;
        $error("command still high after busy rose");
    end

    // write data held from the byte command until busy falls
    wr_data_stable: assert property (@(posedge clk) disable iff (rst)
        (state == ST_WR_WAIT || (cmd_wr_byte_o && $past(cmd_wr_byte_o)))
        |-> $stable(wr_data_o))
    else
    begin
        fail_count++;
        $error("write data changed while host busy");
    end

endmodule

bind autotest_ctrl autotest_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .cmd_rst_o      (cmd_rst_o),
    .cmd_rd_block_o (cmd_rd_block_o),
    .cmd_rd_byte_o  (cmd_rd_byte_o),
    .cmd_wr_block_o (cmd_wr_block_o),
    .cmd_wr_byte_o  (cmd_wr_byte_o),
    .busy_i         (busy_i),
    .wr_data_o      (wr_data_o),
    .state          (state)
);

/* dv/autotest_scoreboard.sv */
// Watches the SD write traffic and halt/fault against the stimulus file.
// Expected block images are rebuilt from the header fields and the seed fill.
module autotest_scoreboard (
    input  logic        clk,
    input  logic        rst,
    input  logic        run_i,
    input  logic        cmd_rst_i,
    input  logic        cmd_rd_block_i,
    input  logic        cmd_wr_block_i,
    input  logic        cmd_wr_byte_i,
    input  logic [31:0] block_addr_i,
    input  logic [7:0]  wr_data_i,
    input  logic        busy_i,
    input  logic        halt_i,
    input  logic        fault_i,
    output int          checks_o,
    output int          errors_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import autotest_pkg::*;

    localparam int FIELDS    = 8;
    localparam int MAX_LINES = 16;
    localparam int F_RUN     = 0;
    localparam int F_ADDR    = 1;
    localparam int F_SIG     = 2;
    localparam int F_COUNT   = 3;
    localparam int F_PT      = 4;
    localparam int F_SEED    = 5;
    localparam int F_HASH    = 6;
    localparam int F_ERR     = 7;

    logic [127:0] stim [FIELDS*MAX_LINES];
    logic [7:0]   image [BLOCK_BYTES];
    int           num_lines;
    int           line_idx;
    int           writes_done;
    int           byte_idx;
    int           checks;
    int           errors;
    logic         halt_seen;
    logic         wr_block_q;

    assign checks_o = checks;
    assign errors_o = errors;

    function automatic logic [127:0] field(input int line, input int f);
        return stim[line*FIELDS + f];
    endfunction

    function automatic int iter_cap(input int line);
        int n;
        n = int'(8'(field(line, F_COUNT)));
        return (n > MAX_ITER) ? MAX_ITER : n;
    endfunction

    function automatic logic is_terminal(input int line);
        return 32'(field(line, F_SIG)) != SIGNATURE || field(line, F_ERR) != 0;
    endfunction

    // hash bytes first, then the cycle count, both low byte first
    function automatic logic [7:0] record_byte(input int line, input int off);
        logic [127:0] h;
        logic [63:0]  cyc;
        h   = field(line, F_HASH);
        cyc = 64'(HASH_ROUNDS);
        if (off < 16)
            return h[8*off +: 8];
        return cyc[8*(off-16) +: 8];
    endfunction

    task automatic load_image(input int line);
        logic [31:0] sig;
        logic [63:0] pt;
        sig = 32'(field(line, F_SIG));
        pt  = 64'(field(line, F_PT));
        for (int i = 0; i < BLOCK_BYTES; i++)
            image[i] = 8'(int'(field(line, F_SEED)) + i);
        for (int i = 0; i < 4; i++)
            image[i] = sig[8*(3-i) +: 8];
        image[4] = 8'(field(line, F_COUNT));
        for (int i = 0; i < 8; i++)
            image[5+i] = pt[8*i +: 8];
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %0h expected %0h", what, got, exp);
        end
    endtask

    task automatic select_line(input int line);
        line_idx    = line;
        writes_done = 0;
        if (line_idx < num_lines && field(line_idx, F_RUN) == 128'(run_i))
            load_image(line_idx);
        else
            line_idx = num_lines;
    endtask

    initial
    begin
        checks = 0;
        errors = 0;
        // unused slots keep the all-ones marker
        for (int i = 0; i < FIELDS*MAX_LINES; i++)
            stim[i] = '1;
        $readmemh("dv/autotest_stimulus.txt", stim);
        num_lines = 0;
        while (num_lines < MAX_LINES && stim[num_lines*FIELDS] !== '1)
            num_lines++;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            int first;
            first = 0;
            while (first < num_lines && field(first, F_RUN) != 128'(run_i))
                first++;
            select_line(first);
            byte_idx   = 0;
            halt_seen  = 1'b0;
            wr_block_q = 1'b0;
        end
        else
        begin
            if (cmd_wr_block_i && !wr_block_q)
            begin
                byte_idx = 0;
                if (line_idx >= num_lines || is_terminal(line_idx))
                begin
                    errors++;
                    $display("block write started where none is expected");
                end
                else
                    check_value("block_addr_o", block_addr_i, 32'(field(line_idx, F_ADDR)));
            end
            if (cmd_wr_byte_i && busy_i && line_idx < num_lines)
            begin
                int rec;
                logic [7:0] exp;
                rec = byte_idx - (HDR_BYTES + REC_BYTES*writes_done);
                if (byte_idx < BLOCK_BYTES)
                begin
                    if (rec >= 0 && rec < REC_BYTES)
                        image[byte_idx] = record_byte(line_idx, rec);
                    exp = image[byte_idx];
                    check_value($sformatf("wr_data_o byte %0d", byte_idx),
                                32'(wr_data_i), 32'(exp));
                end
                byte_idx++;
            end
            if (!cmd_wr_block_i && wr_block_q && line_idx < num_lines)
            begin
                check_value("write byte count", 32'(byte_idx), 32'(BLOCK_BYTES));
                writes_done++;
                if (writes_done >= iter_cap(line_idx))
                    select_line(line_idx + 1);
            end
            wr_block_q = cmd_wr_block_i;

            if (halt_i && !halt_seen)
            begin
                halt_seen = 1'b1;
                if (line_idx >= num_lines || !is_terminal(line_idx) || writes_done != 0)
                begin
                    errors++;
                    $display("halt raised at a block that should have passed");
                end
                else
                begin
                    check_value("block_addr_o", block_addr_i, 32'(field(line_idx, F_ADDR)));
                    check_value("fault_o", 32'(fault_i), 32'(field(line_idx, F_ERR) != 0));
                end
            end
            else if (halt_seen && (cmd_rst_i || cmd_rd_block_i || cmd_wr_block_i))
            begin
                errors++;
                $display("a command was issued after halt");
            end
        end
    end

endmodule

/* dv/tb_autotest.sv */
// Testbench for the SD self-test sequencer with a behavioral SD host and card.
// Run 0 ends on a bad signature, run 1 (after a second reset) on a host error.
module tb_autotest;
    timeunit 1ns;
    timeprecision 1ps;
    import autotest_pkg::*;

    localparam int FIELDS    = 8;
    localparam int MAX_LINES = 16;
    localparam int OP_NONE   = 0;
    localparam int OP_RD     = 1;
    localparam int OP_WR     = 2;

    logic        clk;
    logic        rst;
    logic        run_sel;
    logic        cmd_rst_o;
    logic        cmd_rd_block_o;
    logic        cmd_rd_byte_o;
    logic        cmd_wr_block_o;
    logic        cmd_wr_byte_o;
    logic [31:0] block_addr_o;
    logic [7:0]  wr_data_o;
    logic        busy_i;
    logic [7:0]  rd_data_i;
    logic        err_i;
    logic        halt_o;
    logic        fault_o;
    int          sb_checks;
    int          sb_errors;

    logic [127:0] stim [FIELDS*MAX_LINES];
    bit [7:0]     card [int];
    int           num_lines;
    int           cycle_limit;
    int           cycles;
    int           busy_left;
    int           xfer_idx;
    int           op;
    logic         in_block;

    autotest_top UUT (
        .clk            (clk),
        .rst            (rst),
        .cmd_rst_o      (cmd_rst_o),
        .cmd_rd_block_o (cmd_rd_block_o),
        .cmd_rd_byte_o  (cmd_rd_byte_o),
        .cmd_wr_block_o (cmd_wr_block_o),
        .cmd_wr_byte_o  (cmd_wr_byte_o),
        .block_addr_o   (block_addr_o),
        .wr_data_o      (wr_data_o),
        .busy_i         (busy_i),
        .rd_data_i      (rd_data_i),
        .err_i          (err_i),
        .halt_o         (halt_o),
        .fault_o        (fault_o)
    );

    autotest_scoreboard sb (
        .clk            (clk),
        .rst            (rst),
        .run_i          (run_sel),
        .cmd_rst_i      (cmd_rst_o),
        .cmd_rd_block_i (cmd_rd_block_o),
        .cmd_wr_block_i (cmd_wr_block_o),
        .cmd_wr_byte_i  (cmd_wr_byte_o),
        .block_addr_i   (block_addr_o),
        .wr_data_i      (wr_data_o),
        .busy_i         (busy_i),
        .halt_i         (halt_o),
        .fault_i        (fault_o),
        .checks_o       (sb_checks),
        .errors_o       (sb_errors)
    );

    always #5 clk = ~clk;

    function automatic logic [127:0] field(input int line, input int f);
        return stim[line*FIELDS + f];
    endfunction

    function automatic int card_key(input logic [31:0] addr, input int idx);
        return int'(addr) * BLOCK_BYTES + idx;
    endfunction

    // card image: signature high byte first, plaintext low byte first, seed fill
    task automatic load_card(input int run);
        logic [31:0] addr;
        logic [31:0] sig;
        logic [63:0] pt;
        for (int l = 0; l < num_lines; l++)
        begin
            if (field(l, 0) == 128'(run))
            begin
                addr = 32'(field(l, 1));
                sig  = 32'(field(l, 2));
                pt   = 64'(field(l, 4));
                for (int i = 0; i < BLOCK_BYTES; i++)
                    card[card_key(addr, i)] = 8'(int'(field(l, 5)) + i);
                for (int i = 0; i < 4; i++)
                    card[card_key(addr, i)] = sig[8*(3-i) +: 8];
                card[card_key(addr, 4)] = 8'(field(l, 3));
                for (int i = 0; i < 8; i++)
                    card[card_key(addr, 5+i)] = pt[8*i +: 8];
            end
        end
    endtask

    function automatic logic flagged(input logic [31:0] addr);
        for (int l = 0; l < num_lines; l++)
        begin
            if (field(l, 0) == 128'(run_sel) && 32'(field(l, 1)) == addr
                && field(l, 7) != 0)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic begin_busy(input int kind);
        op        = kind;
        busy_left = 2 + int'($urandom % 5);
        busy_i   <= 1'b1;
    endtask

    // host model, busy length is the back-pressure
    always @(negedge clk)
    begin
        if (rst)
        begin
            busy_i   <= 1'b0;
            err_i    <= 1'b0;
            rd_data_i <= 8'h00;
            busy_left = 0;
            xfer_idx  = 0;
            op        = OP_NONE;
            in_block  = 1'b0;
        end
        else if (busy_left > 0)
        begin
            busy_left--;
            if (busy_left == 0)
            begin
                busy_i <= 1'b0;
                err_i  <= 1'b0;
                if (op == OP_RD)
                begin
                    rd_data_i <= card[card_key(block_addr_o, xfer_idx)];
                    xfer_idx++;
                end
                else if (op == OP_WR)
                begin
                    card[card_key(block_addr_o, xfer_idx)] = wr_data_o;
                    xfer_idx++;
                end
            end
        end
        else if (cmd_rst_o)
        begin
            in_block = 1'b0;
            begin_busy(OP_NONE);
        end
        else if (cmd_rd_byte_o)
            begin_busy(OP_RD);
        else if (cmd_wr_byte_o)
            begin_busy(OP_WR);
        else if ((cmd_rd_block_o || cmd_wr_block_o) && !in_block)
        begin
            in_block = 1'b1;
            xfer_idx = 0;
            begin_busy(OP_NONE);
            if (cmd_rd_block_o && flagged(block_addr_o))
                err_i <= 1'b1;
        end
        else if (!cmd_rd_block_o && !cmd_wr_block_o)
            in_block = 1'b0;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout: halt not reached within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic run_until_halt(input logic run);
        @(negedge clk);
        rst     <= 1'b1;
        run_sel <= run;
        load_card(int'(run));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        while (!halt_o)
            @(posedge clk);
        // stay a while to catch commands after halt
        repeat (20) @(posedge clk);
    endtask

    initial
    begin
        int errors;
        int cap;
        clk         = 1'b0;
        rst         = 1'b1;
        run_sel     = 1'b0;
        busy_i      = 1'b0;
        rd_data_i   = 8'h00;
        err_i       = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        void'($urandom(49475));
        // unused slots keep the all-ones marker
        for (int i = 0; i < FIELDS*MAX_LINES; i++)
            stim[i] = '1;
        $readmemh("dv/autotest_stimulus.txt", stim);
        num_lines = 0;
        while (num_lines < MAX_LINES && stim[num_lines*FIELDS] !== '1)
            num_lines++;
        cycle_limit = 2000;
        for (int l = 0; l < num_lines; l++)
        begin
            cap = int'(8'(field(l, 3)));
            if (cap > MAX_ITER)
                cap = MAX_ITER;
            cycle_limit += (cap + 1) * 1024 * 10;
        end

        run_until_halt(1'b0);
        run_until_halt(1'b1);

        errors = sb_errors + UUT.u_ctrl.u_checker.fail_count;
        $display("closing: %0d checks, %0d errors", sb_checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* all.f */
verilog/autotest_pkg.sv
verilog/autotest_ifs.sv
verilog/block_buffer.sv
verilog/hash_core.sv
verilog/autotest_ctrl.sv
verilog/autotest_top.sv
dv/autotest_checker.sv
dv/autotest_scoreboard.sv
dv/tb_autotest.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_autotest -f all.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$output"; then
    exit 0
fi
exit 1

/* dv/autotest_stimulus.txt */
// run addr sig count plaintext seed expected_hash err_flag (hex, one test block per line)
// run 1 starts after a second reset; err_flag raises err_i on that block's read
0 100 AABBCCDD 02 0000000000000000 11 791479EB86EB86EB86EB861479147914 0
0 101 AABBCCDD 03 FFFFFFFFFFFFFFFF 40 86EB861479147914791479EB86EB86EB 0
0 102 AABBCCDD 19 00000000FFFFFFFF A5 86EB86EB86EB861479147914791479EB 0
0 103 12345678 01 0000000000000000 00 00000000000000000000000000000000 0
1 100 AABBCCDD 01 0000000000000000 22 791479EB86EB86EB86EB861479147914 1
